// ==== fftPkg.sv ====
package fftPkg;

  ////////////////////////////////////////////////////////////////////////////
  // fixed-point widths

  localparam int sampleWidth = 16;  // q1.15 real or imaginary part
  localparam int magWidth    = 17;  // max plus quarter min fits with headroom
  localparam int addrMax     = 8;   // covers frames up to 256 points

  ////////////////////////////////////////////////////////////////////////////
  // data types

  typedef logic signed [sampleWidth-1:0] sample_t;  // one q1.15 word
  typedef logic [magWidth-1:0]           mag_t;     // unsigned magnitude
  typedef logic [addrMax-1:0]            addr_t;    // point index or twiddle index

  typedef struct packed {
    sample_t re;
    sample_t im;
  } complex_t;

  // one butterfly issue, operands read from ram plus rom twiddle
  typedef struct packed {
    complex_t a;      // upper input
    complex_t b;      // lower input
    complex_t w;      // twiddle for the difference path
    addr_t    addrA;  // write-back address of a
    addr_t    addrB;  // write-back address of b
  } bflyIn_t;

  // one butterfly result, written straight back in place
  typedef struct packed {
    complex_t resA;   // halved sum
    complex_t resB;   // halved difference times twiddle
    addr_t    addrA;
    addr_t    addrB;
  } bflyOut_t;

  ////////////////////////////////////////////////////////////////////////////
  // sequencer states

  typedef enum logic [2:0] {
    idle,       // waiting for the first sample
    load,       // filling the frame
    issue,      // one butterfly per cycle
    drain,      // letting the butterfly pipeline empty
    nextStage,  // stage bookkeeping
    readout     // bit-reversed read, natural bin order
  } seqState_t;

endpackage

// ==== butterflyUnit.sv ====
`timescale 1ns/1ps

module butterflyUnit (
  input  logic             clk,
  input  logic             rst,
  input  logic             issue,
  input  fftPkg::bflyIn_t  issueData,
  output logic             done,
  output fftPkg::bflyOut_t result
);

  logic signed [16:0] sumRe;   // a + b, one bit of growth
  logic signed [16:0] sumIm;
  logic signed [16:0] difRe;   // a - b
  logic signed [16:0] difIm;
  logic signed [32:0] accRe;   // combined products
  logic signed [32:0] accIm;

  // stage 1 registers
  logic               s1Valid;
  fftPkg::complex_t   s1Sum;
  fftPkg::complex_t   s1Diff;
  fftPkg::complex_t   s1W;
  fftPkg::addr_t      s1AddrA;
  fftPkg::addr_t      s1AddrB;

  // stage 2 registers
  logic               s2Valid;
  fftPkg::complex_t   s2Sum;
  logic signed [31:0] s2ReRe;  // d.re * w.re
  logic signed [31:0] s2ImIm;  // d.im * w.im
  logic signed [31:0] s2ReIm;  // d.re * w.im
  logic signed [31:0] s2ImRe;  // d.im * w.re
  fftPkg::addr_t      s2AddrA;
  fftPkg::addr_t      s2AddrB;

  always_comb begin
    sumRe = issueData.a.re + issueData.b.re;
    sumIm = issueData.a.im + issueData.b.im;
    difRe = issueData.a.re - issueData.b.re;
    difIm = issueData.a.im - issueData.b.im;
    accRe = s2ReRe - s2ImIm;
    accIm = s2ReIm + s2ImRe;
  end

  // valid bit follows the data down the three stages
  always_ff @(posedge clk) begin
    if (rst) begin
      s1Valid <= 1'b0;
      s2Valid <= 1'b0;
      done    <= 1'b0;
    end else begin
      s1Valid <= issue;
      s2Valid <= s1Valid;
      done    <= s2Valid;  // 3 cycles after issue
    end
  end

  always_ff @(posedge clk) begin
    // stage 1, halve sum and difference (scale 1/2 per stage)
    s1Sum.re  <= sumRe[16:1];
    s1Sum.im  <= sumIm[16:1];
    s1Diff.re <= difRe[16:1];
    s1Diff.im <= difIm[16:1];
    s1W       <= issueData.w;
    s1AddrA   <= issueData.addrA;
    s1AddrB   <= issueData.addrB;
    // stage 2, four q2.30 products
    s2Sum     <= s1Sum;
    s2ReRe    <= s1Diff.re * s1W.re;
    s2ImIm    <= s1Diff.im * s1W.im;
    s2ReIm    <= s1Diff.re * s1W.im;
    s2ImRe    <= s1Diff.im * s1W.re;
    s2AddrA   <= s1AddrA;
    s2AddrB   <= s1AddrB;
    // stage 3, back to q1.15 by shift and truncate
    result.resA    <= s2Sum;
    result.resB.re <= accRe[30:15];
    result.resB.im <= accIm[30:15];
    result.addrA   <= s2AddrA;
    result.addrB   <= s2AddrB;
  end

endmodule

// ==== magnitudeUnit.sv ====
`timescale 1ns/1ps

module magnitudeUnit (
  input  logic             clk,
  input  logic             rst,
  input  logic             readValid,
  input  fftPkg::complex_t value,
  output logic             magValid,
  output fftPkg::mag_t     magnitude
);

  logic [fftPkg::sampleWidth-2:0] absRe;
  logic [fftPkg::sampleWidth-2:0] absIm;
  logic [fftPkg::sampleWidth-2:0] maxV;
  logic [fftPkg::sampleWidth-2:0] minV;
  fftPkg::mag_t                   magNext;

  function automatic logic [fftPkg::sampleWidth-2:0] absSat(fftPkg::sample_t v);
    fftPkg::sample_t neg;
    neg = -v;
    if (!v[fftPkg::sampleWidth-1]) begin
      return v[fftPkg::sampleWidth-2:0];
    end else if (neg[fftPkg::sampleWidth-1]) begin
      return '1;  // -32768 negates to itself, saturate to 32767
    end
    return neg[fftPkg::sampleWidth-2:0];
  endfunction

  always_comb begin
    absRe = absSat(value.re);
    absIm = absSat(value.im);
    if (absRe >= absIm) begin
      maxV = absRe;
      minV = absIm;
    end else begin
      maxV = absIm;
      minV = absRe;
    end
    magNext = fftPkg::mag_t'(maxV) + fftPkg::mag_t'(minV >> 2);  // max + min/4
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      magValid <= 1'b0;
    end else begin
      magValid <= readValid;
    end
  end

  always_ff @(posedge clk) begin
    magnitude <= magNext;
  end

endmodule

// ==== sampleRam.sv ====
`timescale 1ns/1ps

module sampleRam #(
  parameter int pointCount = 64
) (
  input  logic             clk,
  input  logic             loadWe,
  input  fftPkg::addr_t    loadAddr,
  input  fftPkg::complex_t loadData,
  input  fftPkg::addr_t    rdAddrA,
  input  fftPkg::addr_t    rdAddrB,
  input  logic             writeBack,
  input  fftPkg::bflyOut_t writeData,
  output fftPkg::complex_t rdDataA,
  output fftPkg::complex_t rdDataB
);

  localparam int logN = $clog2(pointCount);

  fftPkg::complex_t mem [pointCount];  // frame, updated in place

  always_ff @(posedge clk) begin
    if (loadWe) begin
      mem[loadAddr[logN-1:0]] <= loadData;  // only while not busy
    end
    if (writeBack) begin
      // a butterfly pair never shares an address
      mem[writeData.addrA[logN-1:0]] <= writeData.resA;
      mem[writeData.addrB[logN-1:0]] <= writeData.resB;
    end
    rdDataA <= mem[rdAddrA[logN-1:0]];  // registered read
    rdDataB <= mem[rdAddrB[logN-1:0]];
  end

endmodule

// ==== twiddleRom.sv ====
`timescale 1ns/1ps

module twiddleRom #(
  parameter int pointCount = 64
) (
  input  logic             clk,
  input  fftPkg::addr_t    twiddleIdx,
  output fftPkg::complex_t twiddle
);

  localparam int  logN = $clog2(pointCount);
  localparam int  half = pointCount / 2;     // k runs 0 to N/2-1
  localparam real pi   = 3.14159265358979323846;

  // scale by 2^15, round to nearest, +1.0 clips to 32767
  function automatic fftPkg::sample_t quantize(real x);
    int v;
    v = int'(x * 32768.0);
    if (v > 32767) begin
      v = 32767;
    end
    return fftPkg::sample_t'(v);
  endfunction

  // W(k) = cos(2 pi k / N) - j sin(2 pi k / N)
  function automatic fftPkg::complex_t twEntry(int k);
    real              ang;
    fftPkg::complex_t w;
    ang  = 2.0 * pi * k / pointCount;
    w.re = quantize($cos(ang));
    w.im = quantize(-$sin(ang));
    return w;
  endfunction

  fftPkg::complex_t twTable [half];

  for (genvar k = 0; k < half; k++) begin : genTable
    assign twTable[k] = twEntry(k);  // constant at elaboration
  end

  always_ff @(posedge clk) begin
    twiddle <= twTable[twiddleIdx[logN-2:0]];  // one cycle, same as the ram
  end

endmodule

// ==== fftSequencer.sv ====
`timescale 1ns/1ps

module fftSequencer #(
  parameter int pointCount = 64
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             sampleValid,
  input  fftPkg::sample_t  sample,
  input  fftPkg::complex_t rdDataA,
  input  fftPkg::complex_t rdDataB,
  input  fftPkg::complex_t twiddle,
  output logic             busy,
  output logic             loadWe,
  output fftPkg::addr_t    loadAddr,
  output fftPkg::complex_t loadData,
  output fftPkg::addr_t    rdAddrA,
  output fftPkg::addr_t    rdAddrB,
  output fftPkg::addr_t    twiddleIdx,
  output logic             issue,
  output fftPkg::bflyIn_t  issueData,
  output logic             readValid,
  output logic [7:0]       magBin
);

  localparam int logN = $clog2(pointCount);  // number of stages

  fftPkg::seqState_t state;
  fftPkg::addr_t     loadCnt;     // next point to store
  logic [3:0]        stageCnt;    // s, 0 to logN-1
  fftPkg::addr_t     groupCnt;    // g, 0 to 2^s - 1
  fftPkg::addr_t     offsetCnt;   // j, 0 to h - 1
  logic [1:0]        drainCnt;
  fftPkg::addr_t     binCnt;      // readout bin, natural order

  fftPkg::addr_t     span;        // h = N >> (s+1)
  fftPkg::addr_t     lastGroup;
  fftPkg::addr_t     addrA;       // g*2h + j
  fftPkg::addr_t     addrB;       // g*2h + j + h
  fftPkg::addr_t     addrAQ;      // lined up with ram data
  fftPkg::addr_t     addrBQ;
  fftPkg::addr_t     binQ;        // bin lined up with ram data
  logic              readValidQ;  // lined up with magValid
  logic              accept;
  logic              lastBfly;

  function automatic fftPkg::addr_t bitRev(fftPkg::addr_t v);
    fftPkg::addr_t r;
    r = '0;
    for (int i = 0; i < logN; i++) begin
      r[logN-1-i] = v[i];  // mirror over logN bits only
    end
    return r;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // address generation

  always_comb begin
    span       = fftPkg::addr_t'(pointCount >> (stageCnt + 1));
    lastGroup  = fftPkg::addr_t'((1 << stageCnt) - 1);
    addrA      = (groupCnt << (logN - stageCnt)) + offsetCnt;
    addrB      = addrA + span;
    twiddleIdx = offsetCnt << stageCnt;  // j << s
    lastBfly   = (offsetCnt == span - 1'b1) && (groupCnt == lastGroup);
    rdAddrA    = (state == fftPkg::readout) ? bitRev(binCnt) : addrA;
    rdAddrB    = addrB;

    // busy covers the two cycles of readout tail after the fsm is back in idle
    busy = ((state != fftPkg::idle) && (state != fftPkg::load)) || readValid || readValidQ;
    accept      = sampleValid && !busy;  // strobes while busy are dropped
    loadWe      = accept;
    loadAddr    = loadCnt;
    loadData.re = sample;
    loadData.im = '0;                    // real input frame
  end

  // ram and rom data arrive one cycle after the addresses
  assign issueData = '{a: rdDataA, b: rdDataB, w: twiddle, addrA: addrAQ, addrB: addrBQ};

  ////////////////////////////////////////////////////////////////////////////
  // control fsm

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= fftPkg::idle;
      loadCnt   <= '0;
      stageCnt  <= '0;
      groupCnt  <= '0;
      offsetCnt <= '0;
      drainCnt  <= '0;
      binCnt    <= '0;
    end else begin
      case (state)
        fftPkg::idle: begin
          if (accept) begin
            loadCnt <= loadCnt + 1'b1;  // point 0 written this cycle
            state   <= fftPkg::load;
          end
        end
        fftPkg::load: begin
          if (accept) begin
            if (loadCnt == fftPkg::addr_t'(pointCount - 1)) begin
              loadCnt   <= '0;
              stageCnt  <= '0;
              groupCnt  <= '0;
              offsetCnt <= '0;
              state     <= fftPkg::issue;  // busy rises next cycle
            end else begin
              loadCnt <= loadCnt + 1'b1;
            end
          end
        end
        fftPkg::issue: begin
          if (lastBfly) begin
            groupCnt  <= '0;
            offsetCnt <= '0;
            state     <= fftPkg::drain;
          end else if (offsetCnt == span - 1'b1) begin
            offsetCnt <= '0;                 // next group
            groupCnt  <= groupCnt + 1'b1;
          end else begin
            offsetCnt <= offsetCnt + 1'b1;
          end
        end
        fftPkg::drain: begin
          // 3 drain cycles plus nextStage keep the first read of the
          // next stage behind the last write-back
          if (drainCnt == 2'd2) begin
            drainCnt <= '0;
            state    <= fftPkg::nextStage;
          end else begin
            drainCnt <= drainCnt + 1'b1;
          end
        end
        fftPkg::nextStage: begin
          if (stageCnt == 4'(logN - 1)) begin
            binCnt <= '0;
            state  <= fftPkg::readout;
          end else begin
            stageCnt <= stageCnt + 1'b1;
            state    <= fftPkg::issue;
          end
        end
        fftPkg::readout: begin
          if (binCnt == fftPkg::addr_t'(pointCount - 1)) begin
            binCnt <= '0;
            state  <= fftPkg::idle;
          end else begin
            binCnt <= binCnt + 1'b1;
          end
        end
        default: state <= fftPkg::idle;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // strobe and payload alignment

  always_ff @(posedge clk) begin
    if (rst) begin
      issue      <= 1'b0;
      readValid  <= 1'b0;
      readValidQ <= 1'b0;
    end else begin
      issue      <= (state == fftPkg::issue);    // data valid one cycle later
      readValid  <= (state == fftPkg::readout);
      readValidQ <= readValid;                   // same cycle as magValid
    end
  end

  always_ff @(posedge clk) begin
    addrAQ <= addrA;
    addrBQ <= addrB;
    binQ   <= binCnt;
    magBin <= binQ;  // two cycles, ram read plus magnitude register
  end

endmodule

// ==== fftMagTop.sv ====
`timescale 1ns/1ps

module fftMagTop #(
  parameter int pointCount = 64  // power of two, 8 to 256
) (
  input  logic            clk,
  input  logic            rst,
  input  logic            sampleValid,
  input  fftPkg::sample_t sample,
  output logic            busy,
  output logic            magValid,
  output logic [7:0]      magBin,
  output fftPkg::mag_t    magnitude
);

  logic              loadWe;
  fftPkg::addr_t     loadAddr;
  fftPkg::complex_t  loadData;
  fftPkg::addr_t     rdAddrA;
  fftPkg::addr_t     rdAddrB;
  fftPkg::complex_t  rdDataA;     // also the readout value
  fftPkg::complex_t  rdDataB;
  fftPkg::addr_t     twiddleIdx;
  fftPkg::complex_t  twiddle;
  logic              issue;
  fftPkg::bflyIn_t   issueData;
  logic              writeBack;   // butterfly done strobe
  fftPkg::bflyOut_t  writeData;
  logic              readValid;

  fftSequencer #(.pointCount(pointCount)) i_fftSequencer (
    .clk        (clk),
    .rst        (rst),
    .sampleValid(sampleValid),
    .sample     (sample),
    .rdDataA    (rdDataA),
    .rdDataB    (rdDataB),
    .twiddle    (twiddle),
    .busy       (busy),
    .loadWe     (loadWe),
    .loadAddr   (loadAddr),
    .loadData   (loadData),
    .rdAddrA    (rdAddrA),
    .rdAddrB    (rdAddrB),
    .twiddleIdx (twiddleIdx),
    .issue      (issue),
    .issueData  (issueData),
    .readValid  (readValid),
    .magBin     (magBin)
  );

  sampleRam #(.pointCount(pointCount)) i_sampleRam (
    .clk      (clk),
    .loadWe   (loadWe),
    .loadAddr (loadAddr),
    .loadData (loadData),
    .rdAddrA  (rdAddrA),
    .rdAddrB  (rdAddrB),
    .writeBack(writeBack),
    .writeData(writeData),
    .rdDataA  (rdDataA),
    .rdDataB  (rdDataB)
  );

  twiddleRom #(.pointCount(pointCount)) i_twiddleRom (
    .clk       (clk),
    .twiddleIdx(twiddleIdx),
    .twiddle   (twiddle)
  );

  butterflyUnit i_butterflyUnit (
    .clk      (clk),
    .rst      (rst),
    .issue    (issue),
    .issueData(issueData),
    .done     (writeBack),
    .result   (writeData)
  );

  magnitudeUnit i_magnitudeUnit (
    .clk      (clk),
    .rst      (rst),
    .readValid(readValid),
    .value    (rdDataA),
    .magValid (magValid),
    .magnitude(magnitude)
  );

endmodule

// ==== fftMag_props.sv ====
`timescale 1ns/1ps

module fftMagProps (
  input logic       clk,
  input logic       rst,
  input logic       busy,
  input logic       magValid,
  input logic [7:0] magBin
);

  ////////////////////////////////////////////////////////////////////////////
  // output handshake properties

  // magnitudes only come out while a frame is in flight
  magValidInBusy: assert property (
    @(posedge clk) disable iff (rst) magValid |-> busy
  ) else $error("magValid high while busy is low");

  busyLowAfterReset: assert property (
    @(posedge clk) rst |=> !busy  // fsm back in idle, readout tail cleared
  ) else $error("busy high in the cycle after reset");

  // bins stream out in natural order, one per cycle
  binStep: assert property (
    @(posedge clk) disable iff (rst)
      (magValid && $past(magValid)) |-> (magBin == $past(magBin) + 8'd1)
  ) else $error("magBin did not advance by one between magnitudes");

endmodule

bind fftMagTop fftMagProps i_fftMagProps (
  .clk     (clk),
  .rst     (rst),
  .busy    (busy),
  .magValid(magValid),
  .magBin  (magBin)
);

// ==== fftMagTb.sv ====
`timescale 1ns/1ps

module fftMagTb;

  localparam int  pointCount = 64;
  localparam int  logN       = $clog2(pointCount);
  localparam int  waitLimit  = 4000;  // cycles, well above one frame
  localparam real pi         = 3.14159265358979323846;

  logic            clk;
  logic            rst;
  logic            sampleValid;
  fftPkg::sample_t sample;
  logic            busy;
  logic            magValid;
  logic [7:0]      magBin;
  fftPkg::mag_t    magnitude;

  int seed;
  int checkCount;
  int errorCount;
  int stim   [pointCount];  // real input frame
  int expMag [pointCount];  // model magnitudes, natural bin order
  int gotMag [pointCount];

  fftMagTop #(.pointCount(pointCount)) i_fftMagTop (
    .clk        (clk),
    .rst        (rst),
    .sampleValid(sampleValid),
    .sample     (sample),
    .busy       (busy),
    .magValid   (magValid),
    .magBin     (magBin),
    .magnitude  (magnitude)
  );

  always #5 clk = ~clk;  // 10 ns period

  task automatic compareValue(input string name, input logic [31:0] got, input logic [31:0] exp);
    checkCount++;
    if (got !== exp) begin
      errorCount++;
      $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic reportProblem(input string what);
    errorCount++;
    $display("ERROR: %s", what);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // fixed-point model

  // scale by 2^15, round to nearest, clip +1.0
  function automatic int quantQ15(real x);
    int v;
    v = $rtoi($floor(x * 32768.0 + 0.5));
    if (v > 32767) begin
      v = 32767;
    end
    return v;
  endfunction

  function automatic int wrap16(longint v);
    shortint t;
    t = shortint'(v);  // keep the low 16 bits, signed
    return int'(t);
  endfunction

  function automatic int bitReverse(int v);
    int r;
    r = 0;
    for (int i = 0; i < logN; i++) begin
      r = r | (((v >> i) & 1) << (logN - 1 - i));
    end
    return r;
  endfunction

  function automatic int approxMag(int re, int im);
    int ar;
    int ai;
    int hi;
    int lo;
    ar = (re < 0) ? -re : re;
    ai = (im < 0) ? -im : im;
    ar = (ar > 32767) ? 32767 : ar;  // |-32768| saturates
    ai = (ai > 32767) ? 32767 : ai;
    hi = (ar >= ai) ? ar : ai;
    lo = (ar >= ai) ? ai : ar;
    return hi + (lo >> 2);
  endfunction

  // in-place dif fft, halved each stage, then bit-reversed readout
  task automatic runModel();
    int     re [pointCount];
    int     im [pointCount];
    int     h;
    int     a;
    int     b;
    int     wRe;
    int     wIm;
    int     dRe;
    int     dIm;
    longint pRe;
    longint pIm;
    for (int i = 0; i < pointCount; i++) begin
      re[i] = stim[i];
      im[i] = 0;
    end
    for (int s = 0; s < logN; s++) begin
      h = pointCount >> (s + 1);
      for (int g = 0; g < (1 << s); g++) begin
        for (int j = 0; j < h; j++) begin
          a   = g * 2 * h + j;
          b   = a + h;
          wRe = quantQ15($cos(2.0 * pi * (j << s) / pointCount));
          wIm = quantQ15(-$sin(2.0 * pi * (j << s) / pointCount));
          dRe = wrap16((re[a] - re[b]) >>> 1);  // 17-bit difference, 16 kept
          dIm = wrap16((im[a] - im[b]) >>> 1);
          pRe = longint'(dRe) * wRe - longint'(dIm) * wIm;
          pIm = longint'(dRe) * wIm + longint'(dIm) * wRe;
          re[a] = (re[a] + re[b]) >>> 1;
          im[a] = (im[a] + im[b]) >>> 1;
          re[b] = wrap16(pRe >>> 15);
          im[b] = wrap16(pIm >>> 15);
        end
      end
    end
    for (int k = 0; k < pointCount; k++) begin
      expMag[k] = approxMag(re[bitReverse(k)], im[bitReverse(k)]);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // stimulus and collection

  task automatic dcStim(input int level);
    for (int i = 0; i < pointCount; i++) begin
      stim[i] = level;
    end
  endtask

  task automatic randomStim();
    for (int i = 0; i < pointCount; i++) begin
      stim[i] = wrap16(longint'($random(seed)));
    end
  endtask

  task automatic toneStim(input int bin);
    for (int i = 0; i < pointCount; i++) begin
      stim[i] = $rtoi($floor(32767.0 * $cos(2.0 * pi * bin * i / pointCount) + 0.5));
    end
  endtask

  task automatic sendFrame();
    for (int i = 0; i < pointCount; i++) begin
      if (($random(seed) & 3) == 0) begin
        @(negedge clk);
        sampleValid = 1'b0;  // idle gap between samples
      end
      @(negedge clk);
      compareValue("busy during load", busy, 0);
      sampleValid = 1'b1;
      sample      = fftPkg::sample_t'(stim[i]);
    end
  endtask

  task automatic collectFrame();
    int waited;
    waited = 0;
    @(negedge clk);
    compareValue("busy after last sample", busy, 1);
    while (!magValid && waited < waitLimit) begin
      @(negedge clk);
      waited++;
    end
    if (!magValid) begin
      reportProblem("no magnitude came out before the timeout");
      return;
    end
    for (int k = 0; k < pointCount; k++) begin
      if (!magValid) begin
        reportProblem($sformatf("magValid dropped before bin %0d", k));
        return;
      end
      compareValue("magBin", magBin, k);
      gotMag[k] = int'(magnitude);
      compareValue($sformatf("magnitude bin %0d", k), magnitude, expMag[k]);
      @(negedge clk);
    end
    compareValue("magValid after last bin", magValid, 0);  // exactly N pulses
    compareValue("busy after last bin", busy, 0);
  endtask

  // extra strobes that the dut has to drop
  task automatic strobeWhileBusy();
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (busy && cycles < waitLimit) begin
      sampleValid = (($random(seed) & 1) != 0);
      sample      = fftPkg::sample_t'($random(seed));
      @(negedge clk);
      cycles++;
    end
    sampleValid = 1'b0;
    if (busy) begin
      reportProblem("busy stayed high while extra samples were strobed");
    end
  endtask

  task automatic runFrame(input bit withExtra);
    for (int k = 0; k < pointCount; k++) begin
      gotMag[k] = 0;
    end
    runModel();
    sendFrame();
    fork
      collectFrame();
      if (withExtra) begin
        strobeWhileBusy();
      end else begin
        @(negedge clk);
        sampleValid = 1'b0;
      end
    join
  endtask

  task automatic finishTest(input string name, input int errorsBefore);
    $display("test %-16s done, %0d errors", name, errorCount - errorsBefore);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // test sequence

  initial begin
    int errorsBefore;
    clk         = 1'b0;
    rst         = 1'b1;
    sampleValid = 1'b0;
    sample      = '0;
    seed        = 32'he522_1cae;
    checkCount  = 0;
    errorCount  = 0;
    repeat (5) @(negedge clk);
    rst = 1'b0;

    errorsBefore = errorCount;
    dcStim(12000);
    runFrame(1'b0);
    compareValue("bin 0 nonzero", gotMag[0] != 0, 1);
    finishTest("dc frame", errorsBefore);

    for (int f = 0; f < 4; f++) begin
      errorsBefore = errorCount;
      randomStim();
      runFrame(1'b0);
      finishTest($sformatf("random frame %0d", f), errorsBefore);
    end

    errorsBefore = errorCount;
    toneStim(5);  // full-scale cosine at bin 5
    runFrame(1'b0);
    finishTest("single tone", errorsBefore);

    errorsBefore = errorCount;
    randomStim();
    runFrame(1'b1);  // strobes during processing
    randomStim();
    runFrame(1'b0);  // must match the model without them
    finishTest("ignored samples", errorsBefore);

    errorsBefore = errorCount;
    randomStim();
    runFrame(1'b0);  // bin order and busy fall checked per frame
    finishTest("output order", errorsBefore);

    $display("%0d checks, %0d errors", checkCount, errorCount);
    if (errorCount == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

// ==== project.f ====
fftPkg.sv
butterflyUnit.sv
magnitudeUnit.sv
sampleRam.sv
twiddleRom.sv
fftSequencer.sv
fftMagTop.sv
fftMag_props.sv
fftMagTb.sv

// ==== Makefile ====
LOG = sim.log

.PHONY: sim clean

sim:
	verilator --binary --assert -Wno-fatal --top-module fftMagTb -f project.f -Mdir obj_dir
	./obj_dir/VfftMagTb | tee $(LOG)
	grep -q "ALL CHECKS PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
